// ==== oled_macros.svh ====
// bus address, bit-rate divider, screen geometry and glyph width
// shared by the display sequencer, the bus master and the text memory
`ifndef OLED_MACROS_SVH
`define OLED_MACROS_SVH

// --------------------
// serial bus
// --------------------

// write address byte of the display
`define OLED_BUS_ADDR 8'h78

// slow_clk cycles per quarter bus bit, 2 or more
`define SCL_QUARTER 4

// --------------------
// screen geometry
// --------------------

// pixel columns
`define SCREEN_W 128
// 8-row pages
`define SCREEN_PAGES 8
// pixel columns per glyph
`define GLYPH_W 8

// column bytes in one full frame
`define FRAME_BYTES 1024

// command bytes in the init list, control byte not counted
`define INIT_LEN 6

`endif

// ==== bus_pkg.sv ====
// serial-bus-side types
// bus master state enum and bit counter type
package bus_pkg;

	// bus master states
	typedef enum logic [2:0] {
		IDLE,
		START,
		SEND_BIT,
		ACK_BIT,
		STOP
	} bus_state_t;

	// bit position in a 9-bit byte slot
	// 0..7 data bits, 8 acknowledge
	typedef logic [3:0] bit_cnt_t;

endpackage

// ==== oled_pkg.sv ====
// display-side types
// controller state enum and tile address union
package oled_pkg;

	// --------------------
	// sequencer
	// --------------------

	// controller states
	typedef enum logic [2:0] {
		IDLE,
		INIT_SEQ,
		WIN_SETUP,
		STREAM,
		HALT
	} ctrl_state_t;

	// --------------------
	// text tiles
	// --------------------

	// tile position, page above column
	typedef struct packed {
		logic [2:0] page;
		logic [3:0] col;
	} tile_pos_t;

	// same 7 bits seen as position or as flat text ram index
	// column ends up in the low 4 bits of the index
	typedef union packed {
		logic [6:0] index;
		tile_pos_t  pos;
	} tile_addr_u;

endpackage

// ==== i2c_master.sv ====
// two-wire bus master, write direction only
// quarter-bit divider, byte FSM with acknowledge check, open-drain enables
`include "oled_macros.svh"

module i2c_master
	import bus_pkg::*;
(
	input  logic       slow_clk,
	input  logic       rst,
	input  logic       bus_enable,
	input  logic [7:0] bus_data,
	input  logic       sda_in,
	output logic       bus_ready,
	output logic       bus_next_word,
	output logic       bus_error,
	output logic       scl_oe,
	output logic       sda_oe
);

	localparam int QW = $clog2(`SCL_QUARTER);

	bus_state_t    state;
	logic [QW-1:0] q_cnt;
	logic [1:0]    phase;
	bit_cnt_t      bit_cnt;
	logic [7:0]    shift;
	logic          nack;
	logic          tick;
	logic          bit_end;
	logic          start_req;
	logic          take_word;

	// --------------------
	// timing
	// --------------------

	// quarter-bit strobe
	assign tick = (q_cnt == QW'(`SCL_QUARTER - 1));
	// last quarter of a bus bit
	assign bit_end = tick && (phase == 2'd3);

	assign bus_ready = (state == IDLE);
	// no new transaction after a failed acknowledge
	assign start_req = (state == IDLE) && bus_enable && !bus_error;
	// start of the next byte slot after a good ack
	assign take_word = (state == ACK_BIT) && bit_end && !nack && bus_enable;

	// --------------------
	// byte shifter
	// --------------------
	always_ff @(posedge slow_clk) begin
		if (start_req)
			shift <= `OLED_BUS_ADDR;
		else if (take_word)
			shift <= bus_data;
		else if (bit_end && state == SEND_BIT)
			// msb first
			shift <= {shift[6:0], 1'b0};
	end

	// --------------------
	// bus FSM
	// --------------------
	// phase 0 scl falls, phase 1 sda moves, phase 2 scl rises, phase 3 scl high
	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst) begin
			state         <= IDLE;
			q_cnt         <= '0;
			phase         <= '0;
			bit_cnt       <= '0;
			nack          <= 1'b0;
			scl_oe        <= 1'b0;
			sda_oe        <= 1'b0;
			bus_next_word <= 1'b0;
			bus_error     <= 1'b0;
		end else begin
			bus_next_word <= 1'b0;

			// divider only runs inside a transaction
			if (state == IDLE) begin
				q_cnt <= '0;
				phase <= '0;
				if (start_req)
					state <= START;
			end else begin
				q_cnt <= tick ? '0 : q_cnt + 1'b1;
				if (tick)
					phase <= phase + 1'b1;
			end

			if (tick) begin
				case (state)
					START: begin
						// sda falls while scl is high
						if (phase == 2'd1)
							sda_oe <= 1'b1;
						if (phase == 2'd3) begin
							scl_oe  <= 1'b1;
							bit_cnt <= '0;
							state   <= SEND_BIT;
						end
					end
					SEND_BIT: begin
						if (phase == 2'd0)
							sda_oe <= ~shift[7];
						if (phase == 2'd1)
							scl_oe <= 1'b0;
						if (phase == 2'd3) begin
							scl_oe  <= 1'b1;
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == bit_cnt_t'(7))
								state <= ACK_BIT;
						end
					end
					ACK_BIT: begin
						// release sda for the slave
						if (phase == 2'd0)
							sda_oe <= 1'b0;
						// sample at the rising scl edge
						if (phase == 2'd1) begin
							scl_oe <= 1'b0;
							nack   <= sda_in;
						end
						if (phase == 2'd3) begin
							scl_oe <= 1'b1;
							if (nack) begin
								bus_error <= 1'b1;
								state     <= STOP;
							end else if (bus_enable) begin
								bus_next_word <= 1'b1;
								bit_cnt       <= '0;
								state         <= SEND_BIT;
							end else begin
								state <= STOP;
							end
						end
					end
					STOP: begin
						// sda low under low scl, then rises while scl is high
						if (phase == 2'd0)
							sda_oe <= 1'b1;
						if (phase == 2'd1)
							scl_oe <= 1'b0;
						if (phase == 2'd2)
							sda_oe <= 1'b0;
						if (phase == 2'd3)
							state <= IDLE;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// --------------------
	// checks
	// --------------------

	// a word is only taken on a live enable and lands in the shifter
	a_next_word_enabled: assert property (@(posedge slow_clk) disable iff (rst)
		$rose(bus_next_word) |-> $past(bus_enable) && shift == $past(bus_data));

	// data line moves under low clock, except for start and stop
	a_sda_stable_high: assert property (@(posedge slow_clk) disable iff (rst)
		$changed(sda_oe) |-> scl_oe || state inside {START, STOP});

endmodule

// ==== oled_ctrl.sv ====
// display sequencer: init list, frame window setup and pixel byte stream
// steps hpix and vpage across the frame on taken words
`include "oled_macros.svh"

module oled_ctrl
	import oled_pkg::*;
(
	input  logic       slow_clk,
	input  logic       rst,
	input  logic       update,
	input  logic       bus_ready,
	input  logic       bus_next_word,
	input  logic       bus_error,
	input  logic [7:0] col_byte,
	output logic       bus_enable,
	output logic [7:0] bus_data,
	output logic [6:0] hpix,
	output logic [2:0] vpage
);

	localparam int CNT_W   = $clog2(`FRAME_BYTES + 1);
	localparam int WIN_LEN = 6;

	// --------------------
	// command lists
	// --------------------

	// display off, horizontal addressing, charge pump on, display on
	localparam logic [7:0] INIT_CMDS [`INIT_LEN] = '{
		8'hae, 8'h20, 8'h00, 8'h8d, 8'h14, 8'haf
	};
	// column window 0..127, page window 0..7
	localparam logic [7:0] WIN_CMDS [WIN_LEN] = '{
		8'h21, 8'h00, 8'h7f, 8'h22, 8'h00, 8'h07
	};
	// control bytes heading each transaction
	localparam logic [7:0] CTRL_CMD  = 8'h00;
	localparam logic [7:0] CTRL_DATA = 8'h40;

	ctrl_state_t      state;
	// bytes already taken by the master in this transaction
	logic [CNT_W-1:0] cnt;
	logic             init_done;
	logic [2:0]       cmd_idx;
	logic             last_byte;

	// control byte sits in front of the list
	assign cmd_idx = 3'(cnt - 1'b1);

	// pulse now being seen takes the final byte
	always_comb begin
		case (state)
			INIT_SEQ:  last_byte = (cnt == CNT_W'(`INIT_LEN));
			WIN_SETUP: last_byte = (cnt == CNT_W'(WIN_LEN));
			STREAM:    last_byte = (cnt == CNT_W'(`FRAME_BYTES));
			default:   last_byte = 1'b0;
		endcase
	end

	// --------------------
	// outgoing byte
	// --------------------
	always_comb begin
		bus_data = CTRL_CMD;
		case (state)
			INIT_SEQ: begin
				if (cnt != '0)
					bus_data = INIT_CMDS[cmd_idx];
			end
			WIN_SETUP: begin
				if (cnt != '0)
					bus_data = WIN_CMDS[cmd_idx];
			end
			STREAM: begin
				// col_byte follows hpix and vpage one cycle later
				bus_data = (cnt == '0) ? CTRL_DATA : col_byte;
			end
			default: begin
			end
		endcase
	end

	// --------------------
	// sequencer FSM
	// --------------------
	always_ff @(posedge slow_clk or posedge rst) begin
		if (rst) begin
			state      <= IDLE;
			cnt        <= '0;
			init_done  <= 1'b0;
			bus_enable <= 1'b0;
			hpix       <= '0;
			vpage      <= '0;
		end else if (bus_error) begin
			// dead bus, wait for reset
			state      <= HALT;
			bus_enable <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// frame boundary, only place where update counts
					if (bus_ready && (!init_done || update)) begin
						bus_enable <= 1'b1;
						cnt        <= '0;
						init_done  <= 1'b1;
						state      <= init_done ? WIN_SETUP : INIT_SEQ;
					end
				end
				INIT_SEQ, WIN_SETUP: begin
					if (bus_next_word) begin
						cnt <= cnt + 1'b1;
						if (last_byte) begin
							// master sends stop at the next slot
							bus_enable <= 1'b0;
							cnt        <= '0;
							state      <= (state == INIT_SEQ) ? IDLE : STREAM;
						end
					end
				end
				STREAM: begin
					if (!bus_enable) begin
						// window transaction still closing
						if (bus_ready)
							bus_enable <= 1'b1;
					end else if (bus_next_word) begin
						cnt <= cnt + 1'b1;
						// first pulse takes 0x40, later ones take pixel bytes
						if (cnt != '0) begin
							hpix <= hpix + 1'b1;
							if (hpix == 7'(`SCREEN_W - 1))
								vpage <= vpage + 1'b1;
						end
						if (last_byte) begin
							bus_enable <= 1'b0;
							cnt        <= '0;
							state      <= IDLE;
						end
					end
				end
				default: begin
					bus_enable <= 1'b0;
				end
			endcase
		end
	end

	// --------------------
	// checks
	// --------------------

	// pixel position steps by one column per word taken from the stream
	a_pos_on_word: assert property (@(posedge slow_clk) disable iff (rst)
		$changed({vpage, hpix}) |-> $past(bus_next_word && state == STREAM)
			&& {vpage, hpix} == 10'($past({vpage, hpix}) + 1'b1));

	// new transaction only toward an idle master and from the control byte
	a_enable_on_ready: assert property (@(posedge slow_clk) disable iff (rst)
		$rose(bus_enable) |-> $past(bus_ready) && cnt == '0);

endmodule

// ==== text_tile_mem.sv ====
// text RAM of hex characters, tile address decoding and font lookup
// turns a pixel column position into a registered column byte
`include "oled_macros.svh"

module text_tile_mem
	import oled_pkg::*;
(
	input  logic       slow_clk,
	input  logic       text_we,
	input  logic [6:0] text_addr,
	input  logic [3:0] text_char,
	input  logic [6:0] hpix,
	input  logic [2:0] vpage,
	output logic [7:0] col_byte
);

	localparam int CELLS = (`SCREEN_W / `GLYPH_W) * `SCREEN_PAGES;
	localparam int COL_W = $clog2(`GLYPH_W);
	localparam int GW    = `GLYPH_W * 8;

	logic [3:0]       text_ram [CELLS];
	// one 64-bit word per glyph, column 0 in the top byte
	logic [GW-1:0]    font_rom [16];
	tile_addr_u       tile;
	logic [3:0]       cur_char;
	logic [GW-1:0]    glyph;
	logic [COL_W-1:0] glyph_col;

	initial $readmemh("font.hex", font_rom);

	// --------------------
	// text ram
	// --------------------
	always_ff @(posedge slow_clk) begin
		if (text_we)
			text_ram[text_addr] <= text_char;
	end

	// tile from page and glyph column of the pixel
	always_comb begin
		tile.pos.page = vpage;
		tile.pos.col  = hpix[6:COL_W];
	end

	// flat view indexes the ram
	assign cur_char = text_ram[tile.index];

	// --------------------
	// font lookup
	// --------------------
	assign glyph     = font_rom[cur_char];
	assign glyph_col = hpix[COL_W-1:0];

	always_ff @(posedge slow_clk) begin
		col_byte <= glyph[8 * (`GLYPH_W - 1 - int'(glyph_col)) +: 8];
	end

endmodule

// ==== oled_text_top.sv ====
// top level: display sequencer, bus master and text/font memory
module oled_text_top (
	input  logic       slow_clk,
	input  logic       rst,
	input  logic       update,
	input  logic       text_we,
	input  logic [6:0] text_addr,
	input  logic [3:0] text_char,
	input  logic       sda_in,
	output logic       scl_oe,
	output logic       sda_oe,
	output logic       bus_error
);

	// sequencer to bus master
	logic       bus_enable;
	logic [7:0] bus_data;
	logic       bus_next_word;
	logic       bus_ready;

	// pixel position and its column byte
	logic [6:0] hpix;
	logic [2:0] vpage;
	logic [7:0] col_byte;

	oled_ctrl i_oled_ctrl (
		.slow_clk      (slow_clk),
		.rst           (rst),
		.update        (update),
		.bus_ready     (bus_ready),
		.bus_next_word (bus_next_word),
		.bus_error     (bus_error),
		.col_byte      (col_byte),
		.bus_enable    (bus_enable),
		.bus_data      (bus_data),
		.hpix          (hpix),
		.vpage         (vpage)
	);

	i2c_master i_i2c_master (
		.slow_clk      (slow_clk),
		.rst           (rst),
		.bus_enable    (bus_enable),
		.bus_data      (bus_data),
		.sda_in        (sda_in),
		.bus_ready     (bus_ready),
		.bus_next_word (bus_next_word),
		.bus_error     (bus_error),
		.scl_oe        (scl_oe),
		.sda_oe        (sda_oe)
	);

	text_tile_mem i_text_tile_mem (
		.slow_clk  (slow_clk),
		.text_we   (text_we),
		.text_addr (text_addr),
		.text_char (text_char),
		.hpix      (hpix),
		.vpage     (vpage),
		.col_byte  (col_byte)
	);

endmodule

// ==== tb_oled_text.sv ====
// directed testbench for the text-mode display controller
// bus slave model, font and text models, LFSR, tests and report
`include "oled_macros.svh"

module tb_oled_text;

	// one 9-bit byte slot in slow_clk cycles
	localparam int SLOT        = 9 * 4 * `SCL_QUARTER;
	localparam int CMD_LIMIT   = 16 * SLOT;
	localparam int FRAME_LIMIT = 2 * (`FRAME_BYTES + 32) * SLOT;
	localparam int QUIET_SPAN  = 24 * SLOT;
	localparam int CELLS       = (`SCREEN_W / `GLYPH_W) * `SCREEN_PAGES;
	localparam logic [31:0] LFSR_SEED = 32'ha979_28c4;

	logic       slow_clk;
	logic       rst;
	logic       update;
	logic       text_we;
	logic [6:0] text_addr;
	logic [3:0] text_char;
	logic       sda_in;
	logic       scl_oe;
	logic       sda_oe;
	logic       bus_error;

	// slave model state
	logic       nack      = 1'b0;
	logic       ack_drive = 1'b0;
	logic       scl_prev  = 1'b1;
	logic       sda_prev  = 1'b1;
	logic       scl_now;
	logic       sda_now;
	logic [7:0] shift_in    = '0;
	int         bit_pos     = 0;
	int         cur_first   = 0;
	int         start_count = 0;
	int         nack_count  = 0;
	logic [7:0] rx_bytes [$];
	int         txn_first [$];
	int         txn_len [$];

	// reference models
	logic [63:0] font_model [16];
	logic [3:0]  text_model [CELLS];
	logic [31:0] lfsr;

	int errors       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	bit aborted      = 1'b0;

	oled_text_top i_oled_text_top (
		.slow_clk  (slow_clk),
		.rst       (rst),
		.update    (update),
		.text_we   (text_we),
		.text_addr (text_addr),
		.text_char (text_char),
		.sda_in    (sda_in),
		.scl_oe    (scl_oe),
		.sda_oe    (sda_oe),
		.bus_error (bus_error)
	);

	// open-drain data line, low if either side pulls
	assign sda_in = !(sda_oe || ack_drive);

	initial begin
		slow_clk = 1'b0;
		forever #5 slow_clk = ~slow_clk;
	end

	// --------------------
	// bus slave model
	// --------------------
	// sampled at the falling slow_clk edge, where the enables are settled
	always @(negedge slow_clk) begin
		scl_now = !scl_oe;
		sda_now = !sda_oe;
		if (scl_now && scl_prev && sda_prev && !sda_now) begin
			// start
			start_count++;
			bit_pos   = 0;
			cur_first = rx_bytes.size();
			ack_drive = 1'b0;
		end else if (scl_now && scl_prev && !sda_prev && sda_now) begin
			// stop closes the transaction
			txn_first.push_back(cur_first);
			txn_len.push_back(rx_bytes.size() - cur_first);
			bit_pos   = 0;
			ack_drive = 1'b0;
		end else if (scl_now && !scl_prev) begin
			// data bits msb first, ninth rise is the ack slot
			if (bit_pos < 8)
				shift_in = {shift_in[6:0], sda_now};
			else if (sda_in)
				nack_count++;
			bit_pos++;
			if (bit_pos == 8)
				rx_bytes.push_back(shift_in);
		end else if (!scl_now && scl_prev) begin
			if (bit_pos == 8) begin
				ack_drive = !nack;
			end else if (bit_pos == 9) begin
				ack_drive = 1'b0;
				bit_pos   = 0;
			end
		end
		scl_prev = scl_now;
		sda_prev = sda_now;
	end

	// --------------------
	// helpers
	// --------------------

	// taps 32, 22, 2, 1
	function automatic logic lfsr_next_bit();
		logic fb;
		fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	// four steps per character
	function automatic logic [3:0] rand_char();
		logic [3:0] c;
		c = '0;
		for (int i = 0; i < 4; i++)
			c = {c[2:0], lfsr_next_bit()};
		return c;
	endfunction

	// inputs move 1 unit after the rising edge
	task automatic step();
		@(posedge slow_clk);
		#1;
	endtask

	task automatic write_cell(input logic [6:0] addr, input logic [3:0] ch);
		text_we   = 1'b1;
		text_addr = addr;
		text_char = ch;
		step();
		text_we = 1'b0;
		text_model[addr] = ch;
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic verify_bit(input string name, input logic got, input logic exp);
		assert (got === exp)
		else begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic match_count(input string name, input int got, input int exp);
		assert (got == exp)
		else begin
			$display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// wait for n completed transactions
	task automatic wait_txns(input int n, input int limit, input string what, output bit ok);
		int cyc;
		cyc = 0;
		while (txn_len.size() < n && cyc < limit) begin
			step();
			cyc++;
		end
		ok = (txn_len.size() >= n);
		assert (ok)
		else begin
			$display("ERROR: %s did not end with a stop within %0d cycles", what, limit);
			errors++;
			aborted = 1'b1;
		end
	endtask

	// wait for n start conditions
	task automatic await_starts(input int n, input int limit, input string what, output bit ok);
		int cyc;
		cyc = 0;
		while (start_count < n && cyc < limit) begin
			step();
			cyc++;
		end
		ok = (start_count >= n);
		assert (ok)
		else begin
			$display("ERROR: no start condition for %s within %0d cycles", what, limit);
			errors++;
			aborted = 1'b1;
		end
	endtask

	// address plus seven command-phase bytes, first byte on top
	task automatic cmd_txn(input int t, input string tag, input logic [63:0] bytes);
		logic [63:0] w;
		int          first;
		match_count({tag, " length"}, txn_len[t], 8);
		if (txn_len[t] == 8) begin
			first = txn_first[t];
			w     = bytes;
			for (int i = 0; i < 8; i++) begin
				check_byte($sformatf("%s byte %0d", tag, i), rx_bytes[first + i], w[63:56]);
				w = w << 8;
			end
		end
	endtask

	// address, 0x40, then one column byte per page and pixel column
	task automatic pixel_txn(input int t, input string tag);
		int          first;
		int          page;
		int          col;
		int          tile;
		logic [3:0]  ch;
		logic [63:0] glyph;
		match_count({tag, " length"}, txn_len[t], `FRAME_BYTES + 2);
		if (txn_len[t] == `FRAME_BYTES + 2) begin
			first = txn_first[t];
			check_byte({tag, " address"}, rx_bytes[first], 8'h78);
			check_byte({tag, " control"}, rx_bytes[first + 1], 8'h40);
			for (int n = 0; n < `FRAME_BYTES; n++) begin
				page  = n / `SCREEN_W;
				col   = n % `SCREEN_W;
				tile  = page * (`SCREEN_W / `GLYPH_W) + col / `GLYPH_W;
				ch    = text_model[tile[6:0]];
				// column 0 lands in bits 63..56
				glyph = font_model[ch] << (8 * (col % `GLYPH_W));
				check_byte($sformatf("%s byte %0d", tag, n), rx_bytes[first + 2 + n],
					glyph[63:56]);
			end
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	// --------------------
	// tests
	// --------------------
	task automatic reset_state();
		int e0;
		e0 = errors;
		step();
		verify_bit("scl_oe", scl_oe, 1'b0);
		verify_bit("sda_oe", sda_oe, 1'b0);
		verify_bit("bus_error", bus_error, 1'b0);
		step();
		rst = 1'b0;
		step();
		verify_bit("scl_oe", scl_oe, 1'b0);
		verify_bit("sda_oe", sda_oe, 1'b0);
		verify_bit("bus_error", bus_error, 1'b0);
		finish_test("reset state", e0);
	endtask

	task automatic init_sequence();
		int e0;
		bit ok;
		e0 = errors;
		wait_txns(1, CMD_LIMIT, "init transaction", ok);
		if (ok) begin
			cmd_txn(0, "init", 64'h7800_ae20_008d_14af);
			match_count("nacked bytes", nack_count, 0);
			verify_bit("bus_error", bus_error, 1'b0);
		end
		finish_test("init sequence", e0);
	endtask

	task automatic frame_content();
		int e0;
		bit ok;
		e0 = errors;
		for (int a = 0; a < CELLS; a++)
			write_cell(7'(a), rand_char());
		update = 1'b1;
		wait_txns(3, FRAME_LIMIT, "first frame", ok);
		if (ok) begin
			cmd_txn(1, "window", 64'h7800_2100_7f22_0007);
			pixel_txn(2, "frame 1");
		end
		finish_test("frame content", e0);
	endtask

	task automatic update_freeze();
		int e0;
		int s0;
		bit ok;
		e0 = errors;
		// data transaction of the second frame
		await_starts(5, CMD_LIMIT, "second frame data", ok);
		if (ok) begin
			update = 1'b0;
			for (int a = 0; a < CELLS; a++)
				write_cell(7'(a), rand_char());
			wait_txns(5, FRAME_LIMIT, "frozen frame", ok);
		end
		if (ok) begin
			match_count("frozen frame length", txn_len[4], `FRAME_BYTES + 2);
			s0 = start_count;
			for (int i = 0; i < QUIET_SPAN; i++)
				step();
			assert (start_count == s0)
			else begin
				$display("ERROR: a start condition appeared while update was low");
				errors++;
			end
			update = 1'b1;
			await_starts(6, CMD_LIMIT, "third frame", ok);
		end
		if (ok) begin
			// one more frame only
			update = 1'b0;
			wait_txns(7, FRAME_LIMIT, "third frame", ok);
		end
		if (ok) begin
			cmd_txn(5, "window", 64'h7800_2100_7f22_0007);
			pixel_txn(6, "frame 3");
		end
		finish_test("update freeze", e0);
	endtask

	task automatic ack_failure();
		int e0;
		int s0;
		int cyc;
		bit ok;
		bit quiet;
		e0     = errors;
		nack   = 1'b1;
		update = 1'b1;
		cyc    = 0;
		while (!bus_error && cyc < CMD_LIMIT) begin
			step();
			cyc++;
		end
		ok = bus_error;
		assert (ok)
		else begin
			$display("ERROR: bus_error did not rise after a missing acknowledge");
			errors++;
			aborted = 1'b1;
		end
		if (ok)
			wait_txns(8, CMD_LIMIT, "stop after missing acknowledge", ok);
		if (ok) begin
			match_count("failed transaction length", txn_len[7], 1);
			check_byte("failed address byte", rx_bytes[txn_first[7]], 8'h78);
			match_count("nacked bytes", nack_count, 1);
			s0    = start_count;
			quiet = 1'b1;
			for (int i = 0; i < QUIET_SPAN; i++) begin
				step();
				if (scl_oe || sda_oe || !bus_error || start_count != s0)
					quiet = 1'b0;
			end
			assert (quiet)
			else begin
				$display("ERROR: bus not released and halted after the missing acknowledge");
				errors++;
			end
			update = 1'b0;
			rst    = 1'b1;
			step();
			step();
			verify_bit("bus_error", bus_error, 1'b0);
			nack = 1'b0;
			rst  = 1'b0;
			step();
			verify_bit("scl_oe", scl_oe, 1'b0);
			verify_bit("sda_oe", sda_oe, 1'b0);
			verify_bit("bus_error", bus_error, 1'b0);
		end
		finish_test("acknowledge failure", e0);
	endtask

	// --------------------
	// main sequence
	// --------------------
	initial begin
		rst       = 1'b1;
		update    = 1'b0;
		text_we   = 1'b0;
		text_addr = '0;
		text_char = '0;
		lfsr      = LFSR_SEED;
		for (int i = 0; i < CELLS; i++)
			text_model[i] = '0;
		$readmemh("font.hex", font_model);

		reset_state();
		if (!aborted)
			init_sequence();
		if (!aborted)
			frame_content();
		if (!aborted)
			update_freeze();
		if (!aborted)
			ack_failure();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== font.hex ====
// one glyph word per line, characters 0 to F
// 8 column bytes, column 0 in the top byte, bit 0 is the top pixel row
003E5149453E0000
0000427F40000000
0042615149460000
002141454B310000
001814127F100000
0027454545390000
003C4A4949300000
0001710905030000
0036494949360000
00064949291E0000
007E1111117E0000
007F494949360000
003E414141220000
007F4141221C0000
007F494949410000
007F090909010000

// ==== src.f ====
+incdir+.
bus_pkg.sv
oled_pkg.sv
i2c_master.sv
oled_ctrl.sv
text_tile_mem.sv
oled_text_top.sv
tb_oled_text.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the testbench with Verilator, run it and look for the pass line
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_oled_text
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_oled_text)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation finished: PASS"; then
	exit 0
else
	echo "pass line not found in simulation output"
	exit 1
fi
